// ==== include/music_consts.svh ====
`ifndef MUSIC_CONSTS_SVH
`define MUSIC_CONSTS_SVH

// Song ROM layout
`define SONG_COUNT 4
`define SONG_LEN 8

// Audio stream widths
`define SAMPLE_W 16
`define PHASE_W 16

// Accepted samples per duration unit
`define SAMPLES_PER_BEAT 4

// Phase steps for octave 7 at a 48 kHz frame rate
`define STEP_C 16'd2858
`define STEP_CS 16'd3028
`define STEP_D 16'd3208
`define STEP_DS 16'd3398
`define STEP_E 16'd3600
`define STEP_F 16'd3815
`define STEP_FS 16'd4041
`define STEP_G 16'd4282
`define STEP_GS 16'd4536
`define STEP_A 16'd4806
`define STEP_AS 16'd5092
`define STEP_B 16'd5395

// Button filter, about 10 ms at 100 MHz
`define DEBOUNCE_BITS_DEFAULT 20

`endif

// ==== src/song_pkg.sv ====
`include "music_consts.svh"

package song_pkg;

    // Song number
    typedef logic [$clog2(`SONG_COUNT)-1:0] song_sel_t;

    // Pitch fields
    typedef logic [2:0] octave_t;
    typedef logic [3:0] semitone_t;
    typedef logic [7:0] beats_t;

    // Kind bit, top of every ROM word
    localparam logic KIND_NOTE = 1'b0;
    localparam logic KIND_CTRL = 1'b1;

    // Control ops
    localparam logic OP_REST = 1'b0;
    localparam logic OP_END  = 1'b1;

    // Note view
    typedef struct packed {
        logic      kind;
        octave_t   octave;
        semitone_t semitone;
        beats_t    beats;
    } note_t;

    // Control view, rest or end of song
    typedef struct packed {
        logic       kind;
        logic       op;
        logic [5:0] unused;
        beats_t     beats;
    } ctrl_t;

    // One ROM word, read through either view
    typedef union packed {
        note_t note;
        ctrl_t ctrl;
    } song_word_u;

    // Reader to note player
    typedef struct packed {
        song_word_u word;
        logic       valid;
    } entry_t;

endpackage

// ==== src/audio_pkg.sv ====
`include "music_consts.svh"

package audio_pkg;

    // One stream sample, note_on low during rests
    typedef struct packed {
        logic signed [`SAMPLE_W-1:0] level;
        logic                        note_on;
    } sample_t;

    // Player state seen by the board
    typedef struct packed {
        song_pkg::song_sel_t song;
        logic                playing;
    } status_t;

endpackage

// ==== src/button_press_unit.sv ====
`timescale 1ns/1ps
`include "music_consts.svh"

module button_press_unit #(
    parameter int DEBOUNCE_BITS = `DEBOUNCE_BITS_DEFAULT
) (
    input  logic clk,
    input  logic rst,
    input  logic button,
    output logic press
);

    logic [1:0]               sync;
    logic [DEBOUNCE_BITS-1:0] count;
    logic                     level;
    logic                     level_d;

    always_ff @(posedge clk) begin
        if (rst) begin
            sync    <= '0;
            count   <= '0;
            level   <= 1'b0;
            level_d <= 1'b0;
        end else begin
            // Two-flop synchronizer
            sync    <= {sync[0], button};
            level_d <= level;
            // Level must hold until the counter saturates
            if (sync[1] == level) begin
                count <= '0;
            end else if (&count) begin
                level <= sync[1];
                count <= '0;
            end else begin
                count <= count + 1'b1;
            end
        end
    end

    // Rising edge of the filtered level
    assign press = level & ~level_d;

endmodule

// ==== src/player_ctrl.sv ====
`timescale 1ns/1ps

module player_ctrl (
    input  logic               clk,
    input  logic               rst,
    input  logic               play_press,
    input  logic               next_press,
    input  logic               end_song,
    output audio_pkg::status_t status,
    output logic               restart
);

    always_ff @(posedge clk) begin
        if (rst) begin
            status <= '0;
        end else begin
            // Next song, wraps after the last one
            if (next_press) begin
                status.song <= status.song + 1'b1;
            end
            // End of song wins over a play press
            if (end_song) begin
                status.playing <= 1'b0;
            end else if (play_press) begin
                status.playing <= ~status.playing;
            end
        end
    end

    // Reader back to entry 0
    assign restart = next_press | end_song;

    // Reader sends end of song as a one-cycle pulse
    assert property (@(posedge clk) disable iff (rst)
        end_song |=> !end_song);

endmodule

// ==== src/song_reader.sv ====
`timescale 1ns/1ps
`include "music_consts.svh"

module song_reader (
    input  logic               clk,
    input  logic               rst,
    input  audio_pkg::status_t status,
    input  logic               restart,
    output song_pkg::entry_t   entry,
    input  logic               entry_ready,
    output logic               end_song
);
    import song_pkg::*;

    localparam int IDX_W = $clog2(`SONG_LEN);

    // Fetch FSM
    typedef enum logic [1:0] {
        S_ADDR,
        S_DATA,
        S_OFFER,
        S_DRAIN
    } state_t;

    state_t           state;
    logic [IDX_W-1:0] index;
    logic [15:0]      rom [0:`SONG_COUNT*`SONG_LEN-1];
    song_word_u       rom_q;
    song_word_u       entry_word;
    logic             entry_valid;
    logic             last_index;

    initial $readmemh("src/songs.hex", rom);

    // ========================================
    // ROM, one-cycle read at {song, index}
    // ========================================
    always_ff @(posedge clk) begin
        rom_q <= rom[{status.song, index}];
    end

    assign last_index = (index == IDX_W'(`SONG_LEN - 1));

    // ========================================
    // Sequencing
    // ========================================
    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= S_ADDR;
            index       <= '0;
            entry_valid <= 1'b0;
            end_song    <= 1'b0;
        end else begin
            end_song <= 1'b0;
            if (restart) begin
                // Flush any offer, back to entry 0
                state       <= S_ADDR;
                index       <= '0;
                entry_valid <= 1'b0;
            end else begin
                case (state)
                    S_ADDR: begin
                        if (status.playing) begin
                            state <= S_DATA;
                        end
                    end
                    S_DATA: begin
                        // End words stay here
                        if (rom_q.ctrl.kind == KIND_CTRL && rom_q.ctrl.op == OP_END) begin
                            state <= S_DRAIN;
                        end else begin
                            entry_valid <= 1'b1;
                            state       <= S_OFFER;
                        end
                    end
                    S_OFFER: begin
                        if (entry_ready) begin
                            entry_valid <= 1'b0;
                            if (last_index) begin
                                state <= S_DRAIN;
                            end else begin
                                index <= index + 1'b1;
                                state <= S_ADDR;
                            end
                        end
                    end
                    S_DRAIN: begin
                        // Ready again means the last note is done
                        if (entry_ready) begin
                            end_song <= 1'b1;
                            index    <= '0;
                            state    <= S_ADDR;
                        end
                    end
                    default: state <= S_ADDR;
                endcase
            end
        end
    end

    // Word for the note player
    always_ff @(posedge clk) begin
        if (state == S_DATA) begin
            entry_word <= rom_q;
        end
    end

    assign entry.word  = entry_word;
    assign entry.valid = entry_valid;

    // Offer holds until taken or flushed
    assert property (@(posedge clk) disable iff (rst)
        entry_valid && !entry_ready && !restart |=> entry_valid && $stable(entry_word));

endmodule

// ==== src/note_player.sv ====
`timescale 1ns/1ps
`include "music_consts.svh"

module note_player (
    input  logic               clk,
    input  logic               rst,
    input  logic               playing,
    input  song_pkg::entry_t   entry,
    output logic               entry_ready,
    output audio_pkg::sample_t sample,
    output logic               sample_valid,
    input  logic               sample_ready
);
    import song_pkg::*;

    // Duration in samples, beats times SAMPLES_PER_BEAT
    localparam int DUR_W = 8 + $clog2(`SAMPLES_PER_BEAT);

    logic                 busy;
    logic                 is_note;
    logic [`PHASE_W-1:0]  step;
    logic [`PHASE_W-1:0]  phase;
    logic [DUR_W-1:0]     remaining;
    logic                 take;
    logic                 accept;
    logic                 entry_is_note;
    beats_t               entry_beats;
    logic [`PHASE_W-1:0]  base_step;
    logic [`SAMPLE_W-1:0] centered;

    assign entry_ready   = !busy;
    assign take          = entry.valid && entry_ready;
    assign accept        = sample_valid && sample_ready;
    assign entry_is_note = (entry.word.note.kind == KIND_NOTE);
    // Beats sit in the low byte of both views
    assign entry_beats   = entry.word.note.beats;

    // Octave 7 step per semitone
    always_comb begin
        case (entry.word.note.semitone)
            4'd0:    base_step = `STEP_C;
            4'd1:    base_step = `STEP_CS;
            4'd2:    base_step = `STEP_D;
            4'd3:    base_step = `STEP_DS;
            4'd4:    base_step = `STEP_E;
            4'd5:    base_step = `STEP_F;
            4'd6:    base_step = `STEP_FS;
            4'd7:    base_step = `STEP_G;
            4'd8:    base_step = `STEP_GS;
            4'd9:    base_step = `STEP_A;
            4'd10:   base_step = `STEP_AS;
            4'd11:   base_step = `STEP_B;
            default: base_step = '0;
        endcase
    end

    // Control, sample_valid held until accepted
    always_ff @(posedge clk) begin
        if (rst) begin
            busy         <= 1'b0;
            sample_valid <= 1'b0;
        end else if (take) begin
            // Zero-length entries are skipped
            busy <= (entry_beats != 8'd0);
        end else if (accept) begin
            if (remaining == DUR_W'(1)) begin
                busy         <= 1'b0;
                sample_valid <= 1'b0;
            end else begin
                sample_valid <= playing;
            end
        end else if (busy && playing) begin
            sample_valid <= 1'b1;
        end
    end

    // Phase and duration, both frozen under back-pressure
    always_ff @(posedge clk) begin
        if (take) begin
            is_note   <= entry_is_note;
            step      <= base_step >> (3'd7 - entry.word.note.octave);
            phase     <= '0;
            remaining <= DUR_W'(entry_beats) * DUR_W'(`SAMPLES_PER_BEAT);
        end else if (accept) begin
            phase     <= phase + step;
            remaining <= remaining - 1'b1;
        end
    end

    // Low 15 phase bits doubled, moved to signed range
    assign centered = {~phase[`PHASE_W-2], phase[`PHASE_W-3:0], 1'b0};

    // Top bit picks rising or falling half
    always_comb begin
        sample.note_on = is_note;
        if (!is_note) begin
            sample.level = '0;
        end else if (phase[`PHASE_W-1]) begin
            sample.level = ~centered;
        end else begin
            sample.level = centered;
        end
    end

    // Held sample under back-pressure
    assert property (@(posedge clk) disable iff (rst)
        sample_valid && !sample_ready |=> sample_valid && $stable(sample));

    // Notes in the scale, only rests come as control words
    assert property (@(posedge clk) disable iff (rst)
        take |-> (entry_is_note ? entry.word.note.semitone < 4'd12
                                : entry.word.ctrl.op == OP_REST));

endmodule

// ==== src/music_player.sv ====
`timescale 1ns/1ps
`include "music_consts.svh"

module music_player #(
    parameter int DEBOUNCE_BITS = `DEBOUNCE_BITS_DEFAULT
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               play_btn,
    input  logic               next_btn,
    output audio_pkg::sample_t sample,
    output logic               sample_valid,
    input  logic               sample_ready,
    output audio_pkg::status_t status
);
    import song_pkg::*;

    logic   play_press;
    logic   next_press;
    logic   end_song;
    logic   restart;
    logic   entry_ready;
    entry_t entry;

    // ========================================
    // Button filters
    // ========================================
    button_press_unit #(.DEBOUNCE_BITS(DEBOUNCE_BITS)) i_play_bpu (
        .clk    (clk),
        .rst    (rst),
        .button (play_btn),
        .press  (play_press)
    );

    button_press_unit #(.DEBOUNCE_BITS(DEBOUNCE_BITS)) i_next_bpu (
        .clk    (clk),
        .rst    (rst),
        .button (next_btn),
        .press  (next_press)
    );

    // ========================================
    // Player
    // ========================================
    player_ctrl i_player_ctrl (
        .clk        (clk),
        .rst        (rst),
        .play_press (play_press),
        .next_press (next_press),
        .end_song   (end_song),
        .status     (status),
        .restart    (restart)
    );

    // Song ROM walk
    song_reader i_song_reader (
        .clk         (clk),
        .rst         (rst),
        .status      (status),
        .restart     (restart),
        .entry       (entry),
        .entry_ready (entry_ready),
        .end_song    (end_song)
    );

    // Sample stream out to the codec side
    note_player i_note_player (
        .clk          (clk),
        .rst          (rst),
        .playing      (status.playing),
        .entry        (entry),
        .entry_ready  (entry_ready),
        .sample       (sample),
        .sample_valid (sample_valid),
        .sample_ready (sample_ready)
    );

endmodule

// ==== verif/music_player_tb.sv ====
`timescale 1ns/1ps
`include "music_consts.svh"

module music_player_tb;
    import song_pkg::*;
    import audio_pkg::*;

    localparam int STEP_LIMIT = 400;
    localparam int SONG_LIMIT = 4000;

    logic        clk = 1'b0;
    logic        rst = 1'b1;
    logic        play_btn = 1'b0;
    logic        next_btn = 1'b0;
    logic        sample_ready = 1'b0;
    sample_t     sample;
    logic        sample_valid;
    status_t     status;

    integer      seed = 32'he0f0;
    bit          ready_en = 1'b0;

    // Own copy of the song ROM
    logic [15:0] ref_rom [0:`SONG_COUNT*`SONG_LEN-1];

    // Model state, entry in progress and next ROM index
    song_word_u  cur_word;
    bit          cur_valid = 1'b0;
    bit          song_done = 1'b0;
    int          cur_song = 0;
    int          cur_entry = 0;
    int          cur_pos = 0;
    int          cur_len = 0;
    int          m_song = 0;
    int          m_idx = 0;

    int          accepted = 0;
    int          rest_accepted = 0;
    int          checks = 0;
    int          errors = 0;

    music_player #(.DEBOUNCE_BITS(2)) i_music_player (
        .clk          (clk),
        .rst          (rst),
        .play_btn     (play_btn),
        .next_btn     (next_btn),
        .sample       (sample),
        .sample_valid (sample_valid),
        .sample_ready (sample_ready),
        .status       (status)
    );

    always #20 clk = ~clk;

    // Codec frame requests, ready on about 3 of 4 cycles
    always @(posedge clk) begin
        #1;
        if (ready_en) begin
            sample_ready = ($random(seed) & 3) != 0;
        end else begin
            sample_ready = 1'b0;
        end
    end

    // ========================================
    // Reference model
    // ========================================
    function automatic int base_step(input int semitone);
        case (semitone)
            0:       base_step = `STEP_C;
            1:       base_step = `STEP_CS;
            2:       base_step = `STEP_D;
            3:       base_step = `STEP_DS;
            4:       base_step = `STEP_E;
            5:       base_step = `STEP_F;
            6:       base_step = `STEP_FS;
            7:       base_step = `STEP_G;
            8:       base_step = `STEP_GS;
            9:       base_step = `STEP_A;
            10:      base_step = `STEP_AS;
            11:      base_step = `STEP_B;
            default: base_step = 0;
        endcase
    endfunction

    // Triangle level of sample idx within a note
    function automatic logic signed [15:0] ref_level(input int octave, input int semitone,
                                                     input int idx);
        int step;
        int phase;
        int low;
        step  = base_step(semitone) >> (7 - octave);
        phase = (idx * step) % 65536;
        low   = phase % 32768;
        // Upper half of the phase runs downward
        if (phase >= 32768) begin
            ref_level = 16'(32767 - 2 * low);
        end else begin
            ref_level = 16'(2 * low - 32768);
        end
    endfunction

    function automatic sample_t expected_sample();
        sample_t s;
        s.note_on = (cur_word.note.kind == KIND_NOTE);
        if (s.note_on) begin
            s.level = ref_level(int'(cur_word.note.octave), int'(cur_word.note.semitone),
                                cur_pos);
        end else begin
            s.level = '0;
        end
        return s;
    endfunction

    // Samples in a song up to its end word, or only its rest samples
    function automatic int song_samples(input int song, input bit rests_only);
        song_word_u w;
        int         total;
        int         i;
        total = 0;
        for (i = 0; i < `SONG_LEN; i++) begin
            w = ref_rom[song * `SONG_LEN + i];
            if (w.ctrl.kind == KIND_CTRL && w.ctrl.op == OP_END) begin
                break;
            end
            if (!rests_only || w.ctrl.kind == KIND_CTRL) begin
                total += int'(w.ctrl.beats) * `SAMPLES_PER_BEAT;
            end
        end
        return total;
    endfunction

    // Next entry of the song, or end of song on an end word or past the last index
    function automatic void load_entry();
        song_word_u w;
        cur_valid = 1'b0;
        if (m_idx < `SONG_LEN) begin
            w = ref_rom[m_song * `SONG_LEN + m_idx];
            if (!(w.ctrl.kind == KIND_CTRL && w.ctrl.op == OP_END)) begin
                cur_word  = w;
                cur_valid = 1'b1;
                cur_song  = m_song;
                cur_entry = m_idx;
                cur_pos   = 0;
                cur_len   = int'(w.ctrl.beats) * `SAMPLES_PER_BEAT;
                m_idx++;
            end
        end
        if (!cur_valid) begin
            song_done = 1'b1;
            m_idx     = 0;
        end
    endfunction

    // Reader back at entry 0, current note untouched
    function automatic void model_restart(input int song);
        m_song    = song;
        m_idx     = 0;
        song_done = 1'b0;
    endfunction

    // Samples about to be accepted, checked mid-cycle
    always @(negedge clk) begin : compare
        sample_t exp;
        if (!rst && sample_valid && sample_ready) begin
            if (!cur_valid && !song_done) begin
                load_entry();
            end
            assert (cur_valid)
                else begin
                    $display("Unexpected sample at %0t after song %0d ended", $time, m_song);
                    errors++;
                end
            if (cur_valid) begin
                exp = expected_sample();
                checks++;
                assert (sample == exp)
                    else begin
                        $display("MISMATCH at %0t: entry %0d.%0d pos %0d got %0d/%0b exp %0d/%0b",
                                 $time, cur_song, cur_entry, cur_pos, sample.level,
                                 sample.note_on, exp.level, exp.note_on);
                        errors++;
                    end
                // Rest samples as the DUT marks them
                if (!sample.note_on) begin
                    rest_accepted++;
                end
                accepted++;
                cur_pos++;
                // Note player takes the next entry right after the last sample
                if (cur_pos == cur_len) begin
                    load_entry();
                end
            end
        end
    end

    // ========================================
    // Helpers
    // ========================================
    task automatic poll();
        @(posedge clk);
        #5;
    endtask

    task automatic finish_run();
        $display("Counts: %0d checks, %0d samples, %0d errors", checks, accepted, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    endtask

    task automatic abort_on_timeout(input string what);
        $display("Timeout at %0t: gave up waiting for %s", $time, what);
        errors++;
        finish_run();
    endtask

    task automatic expect_true(input bit ok, input string what);
        checks++;
        assert (ok)
            else begin
                $display("MISMATCH at %0t: %s", $time, what);
                errors++;
            end
    endtask

    task automatic report(input string name, input int errors_before);
        if (errors == errors_before) begin
            $display("Test %s: ok", name);
        end else begin
            $display("Test %s: %0d errors", name, errors - errors_before);
        end
    endtask

    task automatic wait_status(input int song, input bit playing, input int limit,
                               input string what);
        int n;
        n = 0;
        while (!(int'(status.song) == song && status.playing == playing)) begin
            if (n == limit) begin
                abort_on_timeout(what);
            end
            poll();
            n++;
        end
    endtask

    // Playing drops, whatever the song
    task automatic wait_stopped(input int limit, input string what);
        int n;
        n = 0;
        while (status.playing) begin
            if (n == limit) begin
                abort_on_timeout(what);
            end
            poll();
            n++;
        end
    endtask

    task automatic wait_entry(input int song, input int entry, input string what);
        int n;
        n = 0;
        while (!(cur_valid && cur_song == song && cur_entry >= entry)) begin
            if (n == STEP_LIMIT) begin
                abort_on_timeout(what);
            end
            poll();
            n++;
        end
    endtask

    task automatic wait_accepts(input int target, input string what);
        int n;
        n = 0;
        while (accepted < target) begin
            if (n == STEP_LIMIT) begin
                abort_on_timeout(what);
            end
            poll();
            n++;
        end
    endtask

    // Ready low, and any accept already in flight seen by the model
    task automatic stop_ready();
        ready_en = 1'b0;
        poll();
        poll();
    endtask

    // Hold a button until status shows the press, then release
    task automatic press_and_wait(input bit use_next, input int song, input bit playing,
                                  input string what);
        @(posedge clk);
        #1;
        if (use_next) begin
            next_btn = 1'b1;
        end else begin
            play_btn = 1'b1;
        end
        wait_status(song, playing, STEP_LIMIT, what);
        @(posedge clk);
        #1;
        play_btn = 1'b0;
        next_btn = 1'b0;
        // Filter settles low before the next press
        repeat (12) @(posedge clk);
        #5;
    endtask

    // ========================================
    // Test sequence
    // ========================================
    initial begin : main
        int e0;
        int acc0;
        int rest0;
        int ent;
        $readmemh("src/songs.hex", ref_rom);
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        poll();

        e0 = errors;
        expect_true(!sample_valid, "sample_valid high after reset");
        expect_true(status.song == 2'd0 && !status.playing, "status not idle on song 0");
        report("1 reset state", e0);

        // Whole song 0 under random back-pressure
        e0    = errors;
        acc0  = accepted;
        rest0 = rest_accepted;
        ready_en = 1'b1;
        model_restart(0);
        press_and_wait(1'b0, 0, 1'b1, "play on song 0");
        wait_stopped(SONG_LIMIT, "end of song 0");
        expect_true(accepted - acc0 == song_samples(0, 1'b0), "song 0 sample count");
        report("2 song 0 playback", e0);

        e0 = errors;
        expect_true(rest_accepted - rest0 == song_samples(0, 1'b1), "song 0 rest count");
        report("3 rest samples", e0);

        // Stop at the end word, then replay from entry 0
        e0 = errors;
        expect_true(status.song == 2'd0, "song changed at end of song");
        expect_true(song_done && !cur_valid, "song 0 stopped before its last entry");
        expect_true(!sample_valid, "sample offered while stopped");
        model_restart(0);
        press_and_wait(1'b0, 0, 1'b1, "replay of song 0");
        wait_entry(0, 1, "first entry of the replay");
        report("4 end of song and replay", e0);

        e0 = errors;
        stop_ready();
        model_restart(1);
        press_and_wait(1'b1, 1, 1'b1, "next to song 1");
        ready_en = 1'b1;
        wait_entry(1, 1, "first entry of song 1");
        report("5 next song", e0);

        // Pause with a sample held mid-note
        e0 = errors;
        wait_accepts(accepted + 1, "first sample of the note");
        stop_ready();
        ent = cur_entry;
        press_and_wait(1'b0, 1, 1'b0, "pause");
        expect_true(sample_valid, "held sample dropped by pause");
        ready_en = 1'b1;
        wait_accepts(accepted + 1, "held sample to be taken");
        repeat (16) begin
            poll();
            expect_true(!sample_valid, "new sample offered while paused");
        end
        expect_true(cur_valid && cur_entry == ent, "note ended during pause");
        press_and_wait(1'b0, 1, 1'b1, "resume");
        wait_entry(1, ent + 1, "end of the resumed note");
        wait_stopped(SONG_LIMIT, "end of song 1 at the last index");
        expect_true(song_done && status.song == 2'd1, "song 1 did not end after entry 7");
        report("6 pause and resume", e0);

        finish_run();
    end

endmodule

// ==== project.f ====
+incdir+include
src/song_pkg.sv
src/audio_pkg.sv
src/button_press_unit.sv
src/player_ctrl.sv
src/song_reader.sv
src/note_player.sv
src/music_player.sv
verif/music_player_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator and run it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f project.f \
    --top-module music_player_tb \
    -o music_player_sim

./obj_dir/music_player_sim > sim.log 2>&1
cat sim.log

if grep -q "Simulation FAILED" sim.log; then
    exit 1
fi
grep -q "Simulation PASSED" sim.log

// ==== src/songs.hex ====
// One 16-bit word per line, four songs of eight entries each
// Note 0|octave[3]|semitone[4]|beats[8], control 1|op[1]|unused[6]|beats[8], op 1 ends a song
// Song 0, notes and rests, closed by an end word
4001
5402
8001
6701
7902
3B01
8002
C000
// Song 1, eight notes, ends by index wrap
5001
5202
5401
5501
5701
5901
5B01
6001
// Song 2
6001
6401
6701
8001
6702
6402
6001
C000
// Song 3
3901
4001
4401
4702
8002
4701
4401
4002
